// File: hw/noc_types_pkg.sv
package noc_types_pkg;

  localparam int beat_width       = 32;
  localparam int empty_width      = 2;
  localparam int beats_per_packet = 8;

  // node address as carried in two link beats
  typedef struct packed {
    logic [31:0] hw_addr;  // whole first beat
    logic [15:0] sw_addr;
    logic [6:0]  port;
    logic        flag;     // bit 8 of second beat
  } node_addr_t;

  typedef struct packed {
    node_addr_t  dest_addr;
    node_addr_t  src_addr;
    logic [31:0] lamport;
    logic [95:0] data;     // beat 6 in the low word
  } packet_t;

  typedef struct packed {
    logic [beat_width-1:0]  data;
    logic [empty_width-1:0] empty;
    logic                   startofpacket;
    logic                   endofpacket;
  } stream_beat_t;

  typedef logic link_id_t;

  typedef struct packed {
    packet_t  packet;
    link_id_t link;        // link the packet arrived on
  } tagged_packet_t;

endpackage : noc_types_pkg

// File: hw/stream_fifo.sv
`timescale 1ns/100ps

module stream_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  depth     = 4
) (
  input  logic     clk,
  input  logic     reset_n,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  localparam int ptr_width   = (depth > 1) ? $clog2(depth) : 1;
  localparam int count_width = $clog2(depth + 1);

  payload_t               mem [depth];
  logic [ptr_width-1:0]   wr_ptr;
  logic [ptr_width-1:0]   rd_ptr;
  logic [count_width-1:0] count;
  logic [count_width-1:0] count_next;
  logic                   push;
  logic                   pop;

  function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
    return (ptr == ptr_width'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push       = in_valid & in_ready;
  assign pop        = out_valid & out_ready;
  assign out_valid  = (count != '0);
  assign out_data   = mem[rd_ptr];
  assign count_next = count + push - pop;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      in_ready <= 1'b0;  // opens one cycle after reset
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      count    <= count_next;
      in_ready <= (count_next != count_width'(depth));
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule : stream_fifo

// File: hw/packet_receiver.sv
`timescale 1ns/100ps

module packet_receiver import noc_types_pkg::*; #(
  parameter int fifo_depth = 4
) (
  input  logic         clk,
  input  logic         reset_n,
  input  stream_beat_t beat,
  input  logic         valid,
  output logic         ready,
  output logic         packet_valid,
  output packet_t      packet_data,
  output logic         nearly_done,
  output logic         framing_error
);

  typedef enum logic [$clog2(beats_per_packet)-1:0] {
    DEST_ADDR0,
    DEST_ADDR1,
    SRC_ADDR0,
    SRC_ADDR1,
    LAMPORT,
    DATA0,
    DATA1,
    DATA2
  } rx_state_t;

  stream_beat_t fifo_beat;
  logic         fifo_valid;
  logic         deser_ready;
  logic         take;
  logic         finish;
  logic         resync;  // dropping rest of an unstarted packet
  rx_state_t    state;
  packet_t      temp_packet;

  stream_fifo #(
    .payload_t (stream_beat_t),
    .depth     (fifo_depth)
  ) u_beat_fifo (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_data   (beat),
    .in_valid  (valid),
    .in_ready  (ready),
    .out_data  (fifo_beat),
    .out_valid (fifo_valid),
    .out_ready (deser_ready)
  );

  assign take   = fifo_valid & deser_ready;
  assign finish = take & (state == DATA2) & !fifo_beat.startofpacket &
                  fifo_beat.endofpacket;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state         <= DEST_ADDR0;
      resync        <= 1'b0;
      deser_ready   <= 1'b0;
      packet_valid  <= 1'b0;
      nearly_done   <= 1'b0;
      framing_error <= 1'b0;
    end else begin
      deser_ready   <= !finish;  // one idle cycle per packet
      packet_valid  <= finish;
      nearly_done   <= 1'b0;
      framing_error <= 1'b0;
      if (take) begin
        if (fifo_beat.startofpacket) begin
          // a start beat always opens a new packet
          resync        <= 1'b0;
          framing_error <= (state != DEST_ADDR0) | fifo_beat.endofpacket;
          state         <= fifo_beat.endofpacket ? DEST_ADDR0 : DEST_ADDR1;
        end else if (state == DEST_ADDR0) begin
          if (!resync) framing_error <= 1'b1;  // missing sop
          resync <= !fifo_beat.endofpacket;
        end else if (fifo_beat.endofpacket != (state == DATA2)) begin
          framing_error <= 1'b1;  // early or missing eop
          resync        <= !fifo_beat.endofpacket;
          state         <= DEST_ADDR0;
        end else begin
          nearly_done <= (state == DATA1);
          state       <= (state == DATA2) ? DEST_ADDR0 : rx_state_t'(state + 1'b1);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      if (fifo_beat.startofpacket) begin
        temp_packet.dest_addr.hw_addr <= fifo_beat.data;
      end else begin
        case (state)
          DEST_ADDR0: temp_packet.dest_addr.hw_addr <= fifo_beat.data;
          DEST_ADDR1: begin
            {temp_packet.dest_addr.sw_addr, temp_packet.dest_addr.port,
             temp_packet.dest_addr.flag} <= fifo_beat.data[beat_width-1:8];  // low byte unused
          end
          SRC_ADDR0:  temp_packet.src_addr.hw_addr <= fifo_beat.data;
          SRC_ADDR1: begin
            {temp_packet.src_addr.sw_addr, temp_packet.src_addr.port,
             temp_packet.src_addr.flag} <= fifo_beat.data[beat_width-1:8];
          end
          LAMPORT:    temp_packet.lamport <= fifo_beat.data;
          DATA0:      temp_packet.data[31:0] <= fifo_beat.data;
          DATA1:      temp_packet.data[63:32] <= fifo_beat.data;
          default:    ;  // last word goes straight to the output
        endcase
      end
    end
    if (finish) begin
      packet_data            <= temp_packet;
      packet_data.data[95:64] <= fifo_beat.data;
    end
  end

endmodule : packet_receiver

// File: hw/packet_merge.sv
`timescale 1ns/100ps

module packet_merge import noc_types_pkg::*; #(
  parameter int queue_depth = 2
) (
  input  logic           clk,
  input  logic           reset_n,
  input  logic           rx0_valid,
  input  packet_t        rx0_packet,
  input  logic           rx1_valid,
  input  packet_t        rx1_packet,
  output logic           pkt_valid,
  output tagged_packet_t pkt_data
);

  packet_t    q_data [2];
  logic [1:0] q_valid;
  link_id_t   sel_link;
  link_id_t   rr_ptr;  // link favoured on a tie

  stream_fifo #(
    .payload_t (packet_t),
    .depth     (queue_depth)
  ) u_queue0 (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_data   (rx0_packet),
    .in_valid  (rx0_valid),
    .in_ready  (),
    .out_data  (q_data[0]),
    .out_valid (q_valid[0]),
    .out_ready (sel_link == 1'b0)
  );

  stream_fifo #(
    .payload_t (packet_t),
    .depth     (queue_depth)
  ) u_queue1 (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_data   (rx1_packet),
    .in_valid  (rx1_valid),
    .in_ready  (),
    .out_data  (q_data[1]),
    .out_valid (q_valid[1]),
    .out_ready (sel_link == 1'b1)
  );

  always_comb begin
    sel_link        = q_valid[1] & (!q_valid[0] | rr_ptr);
    pkt_valid       = |q_valid;
    pkt_data.packet = q_data[sel_link];
    pkt_data.link   = sel_link;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rr_ptr <= 1'b0;
    end else if (pkt_valid) begin
      rr_ptr <= ~sel_link;  // other link goes first next time
    end
  end

endmodule : packet_merge

// File: hw/dual_link_rx.sv
`timescale 1ns/100ps

module dual_link_rx import noc_types_pkg::*; #(
  parameter int fifo_depth  = 4,
  parameter int queue_depth = 2
) (
  input  logic           clk,
  input  logic           reset_n,
  input  stream_beat_t   link0_beat,
  input  logic           link0_valid,
  output logic           link0_ready,
  input  stream_beat_t   link1_beat,
  input  logic           link1_valid,
  output logic           link1_ready,
  output logic           pkt_valid,
  output tagged_packet_t pkt_data,
  output logic [1:0]     nearly_done,
  output logic [1:0]     framing_error
);

  logic    rx_valid [2];
  packet_t rx_packet [2];

  packet_receiver #(.fifo_depth(fifo_depth)) u_rx0 (
    .clk           (clk),
    .reset_n       (reset_n),
    .beat          (link0_beat),
    .valid         (link0_valid),
    .ready         (link0_ready),
    .packet_valid  (rx_valid[0]),
    .packet_data   (rx_packet[0]),
    .nearly_done   (nearly_done[0]),
    .framing_error (framing_error[0])
  );

  packet_receiver #(.fifo_depth(fifo_depth)) u_rx1 (
    .clk           (clk),
    .reset_n       (reset_n),
    .beat          (link1_beat),
    .valid         (link1_valid),
    .ready         (link1_ready),
    .packet_valid  (rx_valid[1]),
    .packet_data   (rx_packet[1]),
    .nearly_done   (nearly_done[1]),
    .framing_error (framing_error[1])
  );

  packet_merge #(.queue_depth(queue_depth)) u_merge (
    .clk        (clk),
    .reset_n    (reset_n),
    .rx0_valid  (rx_valid[0]),
    .rx0_packet (rx_packet[0]),
    .rx1_valid  (rx_valid[1]),
    .rx1_packet (rx_packet[1]),
    .pkt_valid  (pkt_valid),
    .pkt_data   (pkt_data)
  );

endmodule : dual_link_rx

// File: dv/dual_link_rx_sva.sv
`timescale 1ns/100ps

module dual_link_rx_sva import noc_types_pkg::*; (
  input logic           clk,
  input logic           reset_n,
  input stream_beat_t   link0_beat,
  input logic           link0_valid,
  input logic           link0_ready,
  input stream_beat_t   link1_beat,
  input logic           link1_valid,
  input logic           link1_ready,
  input logic           pkt_valid,
  input tagged_packet_t pkt_data,
  input logic [1:0]     framing_error
);

  // a link yields at most one packet every eight cycles
  assert property (@(posedge clk) disable iff (!reset_n)
    (pkt_valid && pkt_data.link == 1'b0) |=> !(pkt_valid && pkt_data.link == 1'b0) [*7])
    else $error("link 0 packets came out closer than eight cycles");

  assert property (@(posedge clk) disable iff (!reset_n)
    (pkt_valid && pkt_data.link == 1'b1) |=> !(pkt_valid && pkt_data.link == 1'b1) [*7])
    else $error("link 1 packets came out closer than eight cycles");

  assert property (@(posedge clk) disable iff (!reset_n)
    (link0_valid && !link0_ready) |=> (link0_valid && $stable(link0_beat)))
    else $error("link 0 beat changed while stalled");

  assert property (@(posedge clk) disable iff (!reset_n)
    (link1_valid && !link1_ready) |=> (link1_valid && $stable(link1_beat)))
    else $error("link 1 beat changed while stalled");

  assert property (@(posedge clk) disable iff (!reset_n)
    !$isunknown({pkt_valid, framing_error}))
    else $error("pkt_valid or framing_error unknown");

endmodule : dual_link_rx_sva

bind dual_link_rx dual_link_rx_sva u_sva (.*);

// File: dv/tb_dual_link_rx.sv
`timescale 1ns/100ps

module tb_dual_link_rx import noc_types_pkg::*; ();

  localparam int          reset_cycles = 10;
  localparam int          max_gap      = 3;  // two LFSR bits per gap
  localparam int          max_lines    = 64;
  localparam logic [31:0] lfsr_seed    = 32'h932eb47c;
  localparam logic [31:0] lfsr_taps    = 32'h80200003;

  logic           clk = 1'b0;
  logic           reset_n;
  stream_beat_t   beat_in [2];
  logic [1:0]     valid_in;
  logic [1:0]     ready_out;
  logic           pkt_valid;
  tagged_packet_t pkt_data;
  logic [1:0]     nearly_done;
  logic [1:0]     framing_error;

  logic [39:0]    stim [max_lines];  // link, kind, tag
  int             num_lines;
  logic           stim_loaded = 1'b0;
  logic [31:0]    lfsr [2];          // one generator state per link
  tagged_packet_t exp_q [$];
  int             nd_count [2];
  int             fe_count [2];
  int             exp_fe [2];
  int             value_errors;
  int             other_errors;
  int             delivered;

  dual_link_rx #(
    .fifo_depth  (4),
    .queue_depth (2)
  ) u_dual_link_rx (
    .clk           (clk),
    .reset_n       (reset_n),
    .link0_beat    (beat_in[0]),
    .link0_valid   (valid_in[0]),
    .link0_ready   (ready_out[0]),
    .link1_beat    (beat_in[1]),
    .link1_valid   (valid_in[1]),
    .link1_ready   (ready_out[1]),
    .pkt_valid     (pkt_valid),
    .pkt_data      (pkt_data),
    .nearly_done   (nearly_done),
    .framing_error (framing_error)
  );

  always #5 clk = ~clk;

  function automatic logic lfsr_step(input int link);
    logic out;
    out = lfsr[link][0];
    lfsr[link] = lfsr[link] >> 1;
    if (out) lfsr[link] = lfsr[link] ^ lfsr_taps;
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int link, input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_step(link)};
    return v;
  endfunction

  function automatic stream_beat_t make_beat(input logic [31:0] data, input logic sop,
                                             input logic eop);
    stream_beat_t b;
    b.data          = data;
    b.empty         = '0;
    b.startofpacket = sop;
    b.endofpacket   = eop;
    return b;
  endfunction

  // layout rule: low byte of each second address beat is dropped
  function automatic packet_t build_packet(input logic [7:0][31:0] w);
    packet_t p;
    p.dest_addr.hw_addr = w[0];
    p.dest_addr.sw_addr = w[1][31:16];
    p.dest_addr.port    = w[1][15:9];
    p.dest_addr.flag    = w[1][8];
    p.src_addr.hw_addr  = w[2];
    p.src_addr.sw_addr  = w[3][31:16];
    p.src_addr.port     = w[3][15:9];
    p.src_addr.flag     = w[3][8];
    p.lamport           = w[4];
    p.data              = {w[7], w[6], w[5]};
    return p;
  endfunction

  task automatic send_beat(input int link, input stream_beat_t b);
    logic        accepted;
    logic [31:0] gap;
    beat_in[link]  = b;
    valid_in[link] = 1'b1;
    accepted       = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = ready_out[link];  // registered, steady by mid-cycle
      @(posedge clk);
      #1;
    end
    gap = rand_bits(link, 2);
    if (gap != 0) begin
      valid_in[link] = 1'b0;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic send_packet(input int link, input logic [3:0] kind, input logic [31:0] tag);
    logic [7:0][31:0] word;
    tagged_packet_t   exp;
    int               len;
    if (kind == 4'd3) begin
      len = 2 + rand_bits(link, 2);  // partial packet cut by a new start
      for (int i = 0; i < len; i++) begin
        send_beat(link, make_beat(rand_bits(link, 32) ^ tag, i == 0, 1'b0));
      end
      exp_fe[link]++;
    end
    len = (kind == 4'd2) ? 3 + rand_bits(link, 2) : beats_per_packet;
    for (int i = 0; i < len; i++) begin
      word[i] = rand_bits(link, 32) ^ tag;
      if (i == len - 1 && kind != 4'd1 && kind != 4'd2) begin
        exp.packet = build_packet(word);
        exp.link   = link_id_t'(link);
        exp_q.push_back(exp);
      end
      send_beat(link, make_beat(word[i], (i == 0) && (kind != 4'd1), i == len - 1));
    end
    if (kind == 4'd1 || kind == 4'd2) begin
      exp_fe[link]++;
    end
  endtask

  task automatic drive_link(input int link);
    for (int i = 0; i < num_lines; i++) begin
      if (stim[i][39:36] == 4'(link)) send_packet(link, stim[i][35:32], stim[i][31:0]);
    end
    valid_in[link] = 1'b0;
  endtask

  always @(negedge clk) begin : monitor_outputs
    int idx;
    int l;
    if (reset_n) begin
      for (int i = 0; i < 2; i++) begin
        if (nearly_done[i]) nd_count[i]++;
        if (framing_error[i]) fe_count[i]++;
      end
      if (pkt_valid) begin
        l = int'(pkt_data.link);
        if (nd_count[l] != 1) begin
          $display("Error: nearly_done[%0d] pulses expected %h actual %h", l, 1, nd_count[l]);
          value_errors++;
        end
        nd_count[l] = 0;
        idx = -1;
        for (int i = 0; i < exp_q.size(); i++) begin
          if (idx < 0 && exp_q[i].link == pkt_data.link) idx = i;
        end
        if (idx < 0) begin
          $display("a packet came out on link %0d when none was outstanding", l);
          other_errors++;
        end else begin
          if (pkt_data != exp_q[idx]) begin
            $display("Error: pkt_data expected %h actual %h", exp_q[idx], pkt_data);
            value_errors++;
          end
          exp_q.delete(idx);
          delivered++;
        end
      end
    end
  end

  initial begin : watchdog
    int limit;
    wait (stim_loaded);
    limit = num_lines * beats_per_packet * max_gap * 4 + reset_cycles;
    repeat (limit) @(posedge clk);
    $display("run timed out after %0d cycles with %0d packets outstanding", limit, exp_q.size());
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    reset_n    = 1'b0;
    valid_in   = 2'b00;
    beat_in[0] = '0;
    beat_in[1] = '0;
    lfsr[0]    = lfsr_seed;
    lfsr[1]    = lfsr_seed;  // same gaps on both links keeps paired packets in step
    $readmemh("dv/rx_stimulus.hex", stim);
    num_lines = 0;
    while (num_lines < max_lines && !$isunknown(stim[num_lines])) num_lines++;
    if (num_lines == 0) begin
      $display("no stimulus lines were read");
      other_errors++;
    end
    stim_loaded = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1 reset_n = 1'b1;
    @(negedge clk);
    if ({ready_out, pkt_valid, nearly_done, framing_error} != '0) begin
      $display("Error: ready/pkt_valid/nearly_done/framing_error after reset expected %h actual %h",
               7'h0, {ready_out, pkt_valid, nearly_done, framing_error});
      value_errors++;
    end
    @(posedge clk);
    #1;
    fork
      drive_link(0);
      drive_link(1);
    join
    while (exp_q.size() != 0) @(negedge clk);
    repeat (16) @(negedge clk);  // late error pulses
    for (int i = 0; i < 2; i++) begin
      if (fe_count[i] != exp_fe[i]) begin
        $display("Error: framing_error[%0d] count expected %h actual %h", i, exp_fe[i],
                 fe_count[i]);
        value_errors++;
      end
      if (nd_count[i] != 0) begin
        $display("a nearly_done pulse on link %0d was not followed by a packet", i);
        other_errors++;
      end
    end
    $display("packets %0d, value errors %0d, other errors %0d", delivered, value_errors,
             other_errors);
    if (value_errors + other_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule : tb_dual_link_rx

// File: dv/rx_stimulus.hex
// link _ kind _ tag, one packet per line
// kind 0 good, 1 no start, 2 early end, 3 start mid-packet
0_0_1a2b3c4d
1_0_5e6f7081
0_0_92a3b4c5
1_0_d6e7f809
0_1_0badf00d
1_1_13579bdf
0_0_2468ace0
1_2_fedcba98
0_2_0f1e2d3c
1_0_4b5a6978
0_3_87a6b5c4
1_3_d3e2f100
0_0_c0ffee11
1_0_a5a5a5a5
0_0_5a5a5a5a
1_3_77665544
0_2_31415926
1_0_27182818

// File: tb.f
hw/noc_types_pkg.sv
hw/stream_fifo.sv
hw/packet_receiver.sv
hw/packet_merge.sv
hw/dual_link_rx.sv
dv/dual_link_rx_sva.sv
dv/tb_dual_link_rx.sv

// File: Bender.yml
package:
  name: dual_link_rx

sources:
  - hw/noc_types_pkg.sv
  - hw/stream_fifo.sv
  - hw/packet_receiver.sv
  - hw/packet_merge.sv
  - hw/dual_link_rx.sv
  - target: test
    files:
      - dv/dual_link_rx_sva.sv
      - dv/tb_dual_link_rx.sv
